// File: src.f
hw/fade_pkg.sv
hw/raster_timing.sv
hw/fb_scanner.sv
hw/frame_ram.sv
hw/fade_stage.sv
hw/fade_fifo.sv
hw/fb_write_arbiter.sv
hw/gfx_vga_fade.sv
testbench/tb_gfx_vga_fade.sv

// File: Makefile
TOP = tb_gfx_vga_fade

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -o sim

run: build
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^=== PASS ===$$'

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: testbench/tb_gfx_vga_fade.sv
`timescale 1ns/100ps
`default_nettype none

module tb_gfx_vga_fade
  import fade_pkg::*;
();

  localparam int FRAME_CYCLES = H_WHOLE_LINE * V_WHOLE_FRAME;
  localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES + 40;
  localparam int READY_LIMIT  = 64;
  localparam int TABLE_ROWS   = 12;
  localparam int BURST_DRAWS  = 8;

  typedef struct packed {
    fb_x_t  x;
    fb_y_t  y;
    pixel_t color;
    logic   hold;
  } draw_row_t;

  // a run of lit pixels on row 0 keeps the fade path busy at the top of a frame
  localparam draw_row_t DRAW_TABLE [TABLE_ROWS] = '{
    '{4'd2, 3'd0, 12'hf00, 1'b0}, '{4'd3, 3'd0, 12'h0f0, 1'b0},
    '{4'd4, 3'd0, 12'h00f, 1'b0}, '{4'd5, 3'd0, 12'hfff, 1'b0},
    '{4'd6, 3'd0, 12'h888, 1'b0}, '{4'd7, 3'd0, 12'ha5c, 1'b1},
    '{4'd0, 3'd1, 12'heee, 1'b0}, '{4'd15, 3'd2, 12'h3c9, 1'b1},
    '{4'd9, 3'd3, 12'hf0f, 1'b0}, '{4'd4, 3'd5, 12'h7b2, 1'b0},
    '{4'd12, 3'd6, 12'hc41, 1'b0}, '{4'd8, 3'd3, 12'hfff, 1'b1}
  };

  logic   clk;
  logic   reset;
  fb_x_t  gfx_x;
  fb_y_t  gfx_y;
  pixel_t gfx_color;
  logic   gfx_valid;
  logic   gfx_ready;
  logic   vga_enable;
  color_t vga_red;
  color_t vga_grn;
  color_t vga_blu;
  logic   vga_hsync;
  logic   vga_vsync;

  // scoreboard, age above color as stored in the frame ram
  fb_word_t model [FB_WORDS];
  int       errors = 0;
  int       tests_run = 0;
  int       tests_passed = 0;
  int       stall_cycles = 0;

  // raster tracking of the position shown at the outputs
  logic   tracking = 1'b0;
  logic   fresh = 1'b0;
  logic   prev_vsync = 1'b1;
  int     out_h = 0;
  int     out_v = 0;
  int     vsync_falls = 0;
  pixel_t held_pixel;
  logic   held_hsync;
  logic   held_vsync;

  gfx_vga_fade u_gfx_vga_fade (
    .clk        (clk),
    .reset      (reset),
    .gfx_x      (gfx_x),
    .gfx_y      (gfx_y),
    .gfx_color  (gfx_color),
    .gfx_valid  (gfx_valid),
    .gfx_ready  (gfx_ready),
    .vga_enable (vga_enable),
    .vga_red    (vga_red),
    .vga_grn    (vga_grn),
    .vga_blu    (vga_blu),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_color(input string name, input color_t got, input color_t exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_sync(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // one display of a lit pixel lowers its age, halving at the half age, black at zero
  function automatic fb_word_t faded_word(input fb_word_t word);
    age_t   age;
    pixel_t color;
    age = word[15:12];
    color = word[11:0];
    if (color == '0 || age == '0) begin
      return word;
    end
    age = age - age_t'(1);
    if (age == '0) begin
      color = '0;
    end else if (age == age_t'(FADE_HALF_AGE)) begin
      color = {color[11:8] >> 1, color[7:4] >> 1, color[3:0] >> 1};
    end
    return {age, color};
  endfunction

  task automatic show_position();
    logic   vis;
    int     idx;
    pixel_t exp_pixel;
    vis = (out_h < H_VISIBLE) && (out_v < V_VISIBLE);
    idx = out_v * H_VISIBLE + out_h;
    exp_pixel = vis ? model[idx][11:0] : '0;
    held_pixel = exp_pixel;
    held_hsync = !(out_h >= H_SYNC_START && out_h < H_SYNC_END);
    held_vsync = !(out_v >= V_SYNC_START && out_v < V_SYNC_END);
    check_pixel($sformatf("vga_rgb at (%0d,%0d)", out_h, out_v),
                {vga_red, vga_grn, vga_blu}, exp_pixel);
    check_sync($sformatf("vga_hsync at (%0d,%0d)", out_h, out_v), vga_hsync, held_hsync);
    check_sync($sformatf("vga_vsync at (%0d,%0d)", out_h, out_v), vga_vsync, held_vsync);
    if (vis) model[idx] = faded_word(model[idx]);
    if (out_h == 0 && out_v == V_SYNC_START) vsync_falls++;
  endtask

  // outputs are sampled in the middle of the cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (!tracking && prev_vsync && !vga_vsync) begin
        tracking = 1'b1;
        fresh = 1'b1;
        out_h = 0;
        out_v = V_SYNC_START;
      end
      prev_vsync = vga_vsync;
      if (tracking) begin
        if (fresh) begin
          show_position();
        end else begin
          check_pixel("vga_rgb during pause", {vga_red, vga_grn, vga_blu}, held_pixel);
          check_sync("vga_hsync during pause", vga_hsync, held_hsync);
          check_sync("vga_vsync during pause", vga_vsync, held_vsync);
        end
        // the next edge moves the outputs only if the display is enabled
        fresh = vga_enable;
        if (vga_enable) begin
          out_h++;
          if (out_h == H_WHOLE_LINE) begin
            out_h = 0;
            out_v = (out_v == V_WHOLE_FRAME - 1) ? 0 : out_v + 1;
          end
        end
      end
      if (gfx_valid && gfx_ready) begin
        model[int'(gfx_y) * H_VISIBLE + int'(gfx_x)] = {age_t'(FADE_START_AGE), gfx_color};
      end
    end
  end

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic draw_pixel(input fb_x_t x, input fb_y_t y, input pixel_t color,
                            input logic hold);
    int waited;
    waited = 0;
    gfx_x = x;
    gfx_y = y;
    gfx_color = color;
    gfx_valid = 1'b1;
    while (!gfx_ready && waited < READY_LIMIT) begin
      step();
      waited++;
      stall_cycles++;
    end
    if (!gfx_ready) begin
      $display("draw to (%0d,%0d) was never accepted", x, y);
      errors++;
    end else begin
      step();
    end
    gfx_valid = 1'b0;
    if (hold) step();
  endtask

  task automatic draw_table();
    for (int i = 0; i < TABLE_ROWS; i++) begin
      draw_pixel(DRAW_TABLE[i].x, DRAW_TABLE[i].y, DRAW_TABLE[i].color, DRAW_TABLE[i].hold);
    end
  endtask

  task automatic wait_vsync_fall(input int count);
    int start;
    int n;
    for (int i = 0; i < count; i++) begin
      start = vsync_falls;
      n = 0;
      while (vsync_falls == start && n < WAIT_LIMIT) begin
        step();
        n++;
      end
      if (vsync_falls == start) begin
        $display("timed out waiting for the start of vertical sync");
        errors++;
      end
    end
  endtask

  task automatic wait_position(input int h, input int v);
    int n;
    n = 0;
    while (!(out_h == h && out_v == v) && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (!(out_h == h && out_v == v)) begin
      $display("timed out waiting for raster position (%0d,%0d)", h, v);
      errors++;
    end
  endtask

  task automatic measure_frame();
    int   h_falls;
    int   h_low;
    int   v_falls;
    int   v_low;
    int   last_fall;
    logic prev_h;
    logic prev_v;
    h_falls = 0;
    h_low = 0;
    v_falls = 0;
    v_low = 0;
    last_fall = -1;
    prev_h = vga_hsync;
    prev_v = vga_vsync;
    for (int n = 0; n < FRAME_CYCLES; n++) begin
      if (!vga_hsync) h_low++;
      if (!vga_vsync) v_low++;
      if (prev_h && !vga_hsync) begin
        if (last_fall >= 0) check_count("hsync pulse spacing", n - last_fall, H_WHOLE_LINE);
        last_fall = n;
        h_falls++;
      end
      if (prev_v && !vga_vsync) v_falls++;
      prev_h = vga_hsync;
      prev_v = vga_vsync;
      step();
    end
    check_count("hsync pulses per frame", h_falls, V_WHOLE_FRAME);
    check_count("hsync low cycles", h_low, V_WHOLE_FRAME * H_SYNC_PULSE);
    check_count("vsync pulses per frame", v_falls, 1);
    check_count("vsync low cycles", v_low, V_SYNC_PULSE * H_WHOLE_LINE);
  endtask

  task automatic finish_test(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - start_errors);
    end
  endtask

  initial begin
    int     seed_val;
    int     start_errors;
    int     n;
    pixel_t burst_color;
    seed_val = $urandom(32'hcd3e117f);
    reset = 1'b1;
    gfx_x = '0;
    gfx_y = '0;
    gfx_color = '0;
    gfx_valid = 1'b0;
    vga_enable = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    step();

    start_errors = errors;
    check_sync("vga_hsync", vga_hsync, 1'b1);
    check_sync("vga_vsync", vga_vsync, 1'b1);
    check_color("vga_red", vga_red, '0);
    check_color("vga_grn", vga_grn, '0);
    check_color("vga_blu", vga_blu, '0);
    check_sync("gfx_ready", gfx_ready, 1'b1);
    finish_test("reset state", start_errors);

    // black pixels never fade, so the display can start on a cleared buffer
    for (int y = 0; y < V_VISIBLE; y++) begin
      for (int x = 0; x < H_VISIBLE; x++) begin
        draw_pixel(fb_x_t'(x), fb_y_t'(y), '0, 1'b0);
      end
    end

    start_errors = errors;
    vga_enable = 1'b1;
    n = 0;
    while (!tracking && n < WAIT_LIMIT) begin
      step();
      n++;
    end
    if (!tracking) begin
      $display("no falling vsync seen after the display was enabled");
      errors++;
    end
    measure_frame();
    finish_test("raster timing", start_errors);

    start_errors = errors;
    wait_vsync_fall(1);
    draw_table();
    wait_vsync_fall(2);
    finish_test("draw and first display", start_errors);

    start_errors = errors;
    wait_vsync_fall(3);
    finish_test("fade sequence", start_errors);

    // redraw in blanking, then draw row 7 while row 0 is fading
    start_errors = errors;
    wait_vsync_fall(1);
    draw_table();
    wait_position(0, 0);
    stall_cycles = 0;
    for (int i = 0; i < BURST_DRAWS; i++) begin
      burst_color = pixel_t'($urandom());
      if (burst_color == '0) burst_color = 12'h001;
      draw_pixel(fb_x_t'(i), fb_y_t'(V_VISIBLE - 1), burst_color, 1'b0);
    end
    if (stall_cycles == 0) begin
      $display("gfx_ready never dropped during the draw burst");
      errors++;
    end
    wait_vsync_fall(2);
    finish_test("back-pressure", start_errors);

    // pause on a lit pixel with another lit pixel held in the read stage
    start_errors = errors;
    wait_position(8, 3);
    vga_enable = 1'b0;
    repeat (40) step();
    vga_enable = 1'b1;
    wait_vsync_fall(3);
    finish_test("display pause", start_errors);

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_passed, tests_run - tests_passed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/gfx_vga_fade.sv
`timescale 1ns/100ps
`default_nettype none

module gfx_vga_fade
  import fade_pkg::*;
(
  input  logic   clk,
  input  logic   reset,

  // drawing port
  input  fb_x_t  gfx_x,
  input  fb_y_t  gfx_y,
  input  pixel_t gfx_color,
  input  logic   gfx_valid,
  output logic   gfx_ready,

  // display
  input  logic   vga_enable,
  output color_t vga_red,
  output color_t vga_grn,
  output color_t vga_blu,
  output logic   vga_hsync,
  output logic   vga_vsync
);

  // raster position
  logic     rt_visible;
  fb_addr_t rt_addr;
  logic     rt_hsync;
  logic     rt_vsync;

  // frame ram
  fb_addr_t rd_addr;
  fb_word_t rd_data;
  logic     we;
  fb_addr_t waddr;
  fb_word_t wdata;

  // displayed pixel
  logic     pix_valid;
  pixel_t   pix_color;
  age_t     pix_age;
  fb_addr_t pix_addr;

  // fade path
  logic     fade_push;
  fb_addr_t fade_addr;
  fb_word_t fade_word;
  logic     fade_pop;
  logic     fade_empty;
  logic     fade_almost_full;
  fb_addr_t head_addr;
  fb_word_t head_word;

  raster_timing u_raster_timing (
    .clk     (clk),
    .reset   (reset),
    .enable  (vga_enable),
    .h_count (),
    .v_count (),
    .visible (rt_visible),
    .addr    (rt_addr),
    .hsync   (rt_hsync),
    .vsync   (rt_vsync)
  );

  fb_scanner u_fb_scanner (
    .clk       (clk),
    .reset     (reset),
    .enable    (vga_enable),
    .visible   (rt_visible),
    .addr      (rt_addr),
    .hsync     (rt_hsync),
    .vsync     (rt_vsync),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .pix_valid (pix_valid),
    .pix_color (pix_color),
    .pix_age   (pix_age),
    .pix_addr  (pix_addr),
    .pix_hsync (vga_hsync),
    .pix_vsync (vga_vsync)
  );

  frame_ram u_frame_ram (
    .clk     (clk),
    .we      (we),
    .waddr   (waddr),
    .wdata   (wdata),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  fade_stage u_fade_stage (
    .clk       (clk),
    .reset     (reset),
    .pix_valid (pix_valid),
    .pix_color (pix_color),
    .pix_age   (pix_age),
    .pix_addr  (pix_addr),
    .fade_push (fade_push),
    .fade_addr (fade_addr),
    .fade_word (fade_word)
  );

  fade_fifo u_fade_fifo (
    .clk         (clk),
    .reset       (reset),
    .push        (fade_push),
    .push_addr   (fade_addr),
    .push_word   (fade_word),
    .pop         (fade_pop),
    .empty       (fade_empty),
    .almost_full (fade_almost_full),
    .head_addr   (head_addr),
    .head_word   (head_word)
  );

  fb_write_arbiter u_fb_write_arbiter (
    .clk              (clk),
    .reset            (reset),
    .fade_empty       (fade_empty),
    .fade_almost_full (fade_almost_full),
    .fade_addr        (head_addr),
    .fade_word        (head_word),
    .fade_pop         (fade_pop),
    .gfx_x            (gfx_x),
    .gfx_y            (gfx_y),
    .gfx_color        (gfx_color),
    .gfx_valid        (gfx_valid),
    .gfx_ready        (gfx_ready),
    .we               (we),
    .waddr            (waddr),
    .wdata            (wdata)
  );

  assign {vga_red, vga_grn, vga_blu} = pix_color;

endmodule

`default_nettype wire

// File: hw/fb_write_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module fb_write_arbiter
  import fade_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     fade_empty,
  input  logic     fade_almost_full,
  input  fb_addr_t fade_addr,
  input  fb_word_t fade_word,
  output logic     fade_pop,
  input  fb_x_t    gfx_x,
  input  fb_y_t    gfx_y,
  input  pixel_t   gfx_color,
  input  logic     gfx_valid,
  output logic     gfx_ready,
  output logic     we,
  output fb_addr_t waddr,
  output fb_word_t wdata
);

  fb_addr_t gfx_addr;
  fb_word_t gfx_word;
  logic     gfx_fire;
  logic     fade_busy_q;

  assign gfx_addr = fb_addr_t'(fb_addr_t'(gfx_y) * fb_addr_t'(H_VISIBLE) + fb_addr_t'(gfx_x));

  // every client pixel starts its life at full age
  assign gfx_word = {age_t'(FADE_START_AGE), gfx_color};

  // fade write-backs always win the port
  assign fade_pop = !fade_empty;

  // the client gets the port back one idle cycle after the last fade write
  assign gfx_ready = fade_empty && !fade_almost_full && !fade_busy_q;
  assign gfx_fire  = gfx_valid && gfx_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      fade_busy_q <= 1'b0;
    end else begin
      fade_busy_q <= fade_pop;
    end
  end

  always_comb begin
    we    = fade_pop || gfx_fire;
    waddr = gfx_addr;
    wdata = gfx_word;
    if (fade_pop) begin
      waddr = fade_addr;
      wdata = fade_word;
    end
  end

endmodule

`default_nettype wire

// File: hw/fade_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module fade_fifo
  import fade_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  fb_addr_t push_addr,
  input  fb_word_t push_word,
  input  logic     pop,
  output logic     empty,
  output logic     almost_full,
  output fb_addr_t head_addr,
  output fb_word_t head_word
);

  typedef logic [FADE_FIFO_PTR_W-1:0]   ptr_t;
  typedef logic [FADE_FIFO_COUNT_W-1:0] count_t;

  fb_addr_t addr_mem [FADE_FIFO_DEPTH];
  fb_word_t word_mem [FADE_FIFO_DEPTH];
  ptr_t     wr_ptr;
  ptr_t     rd_ptr;
  count_t   count;
  logic     full;
  logic     do_push;
  logic     do_pop;

  function automatic ptr_t ptr_next(input ptr_t ptr);
    return (ptr == ptr_t'(FADE_FIFO_DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
  endfunction

  assign empty       = (count == '0);
  assign full        = (count == count_t'(FADE_FIFO_DEPTH));
  assign almost_full = (count >= count_t'(FADE_FIFO_ALMOST_FULL));
  assign do_push     = push && !full;
  assign do_pop      = pop && !empty;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_next(wr_ptr);
      if (do_pop) rd_ptr <= ptr_next(rd_ptr);
      if (do_push && !do_pop) begin
        count <= count + count_t'(1);
      end else if (do_pop && !do_push) begin
        count <= count - count_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      addr_mem[wr_ptr] <= push_addr;
      word_mem[wr_ptr] <= push_word;
    end
  end

  // first word fall through
  assign head_addr = addr_mem[rd_ptr];
  assign head_word = word_mem[rd_ptr];

endmodule

`default_nettype wire

// File: hw/fade_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fade_stage
  import fade_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     pix_valid,
  input  pixel_t   pix_color,
  input  age_t     pix_age,
  input  fb_addr_t pix_addr,
  output logic     fade_push,
  output fb_addr_t fade_addr,
  output fb_word_t fade_word
);

  color_t red;
  color_t grn;
  color_t blu;
  logic   lit;
  age_t   next_age;
  pixel_t next_color;

  assign {red, grn, blu} = pix_color;

  // black pixels and pixels already at age zero are left alone
  assign lit = pix_valid && (pix_color != '0) && (pix_age != '0);

  always_comb begin
    next_age = pix_age - age_t'(1);
    if (next_age == '0) begin
      next_color = '0;
    end else if (next_age == age_t'(FADE_HALF_AGE)) begin
      next_color = {red >> 1, grn >> 1, blu >> 1};
    end else begin
      next_color = pix_color;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fade_push <= 1'b0;
    end else begin
      fade_push <= lit;
    end
  end

  always_ff @(posedge clk) begin
    if (lit) begin
      fade_addr <= pix_addr;
      fade_word <= {next_age, next_color};
    end
  end

endmodule

`default_nettype wire

// File: hw/frame_ram.sv
`timescale 1ns/100ps
`default_nettype none

module frame_ram
  import fade_pkg::*;
(
  input  logic     clk,
  input  logic     we,
  input  fb_addr_t waddr,
  input  fb_word_t wdata,
  input  fb_addr_t rd_addr,
  output fb_word_t rd_data
);

  fb_word_t mem [FB_WORDS];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // read before write on a same-address collision
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: hw/fb_scanner.sv
`timescale 1ns/100ps
`default_nettype none

module fb_scanner
  import fade_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     enable,
  input  logic     visible,
  input  fb_addr_t addr,
  input  logic     hsync,
  input  logic     vsync,
  output fb_addr_t rd_addr,
  input  fb_word_t rd_data,
  output logic     pix_valid,
  output pixel_t   pix_color,
  output age_t     pix_age,
  output fb_addr_t pix_addr,
  output logic     pix_hsync,
  output logic     pix_vsync
);

  logic     vis_d1;
  logic     hsync_d1;
  logic     vsync_d1;
  fb_addr_t addr_d1;
  age_t     rd_age;
  pixel_t   rd_color;

  assign {rd_age, rd_color} = rd_data;

  // while paused, keep re-reading the word of the position held in stage one,
  // so the ram output still matches it when the display resumes
  assign rd_addr = enable ? addr : addr_d1;

  // stage one, in step with the ram read
  always_ff @(posedge clk) begin
    if (reset) begin
      vis_d1   <= 1'b0;
      hsync_d1 <= 1'b1;
      vsync_d1 <= 1'b1;
    end else if (enable) begin
      vis_d1   <= visible;
      hsync_d1 <= hsync;
      vsync_d1 <= vsync;
    end
  end

  always_ff @(posedge clk) begin
    if (enable) begin
      addr_d1  <= addr;
      pix_addr <= addr_d1;
    end
  end

  // stage two, the output register
  always_ff @(posedge clk) begin
    if (reset) begin
      pix_valid <= 1'b0;
      pix_color <= '0;
      pix_age   <= '0;
      pix_hsync <= 1'b1;
      pix_vsync <= 1'b1;
    end else begin
      // one pulse per displayed pixel, so a pause does not age it twice
      pix_valid <= enable && vis_d1;
      if (enable) begin
        pix_color <= vis_d1 ? rd_color : '0;
        pix_age   <= vis_d1 ? rd_age : '0;
        pix_hsync <= hsync_d1;
        pix_vsync <= vsync_d1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/raster_timing.sv
`timescale 1ns/100ps
`default_nettype none

module raster_timing
  import fade_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     enable,
  output h_count_t h_count,
  output v_count_t v_count,
  output logic     visible,
  output fb_addr_t addr,
  output logic     hsync,
  output logic     vsync
);

  logic h_last;
  logic v_last;

  assign h_last = (h_count == h_count_t'(H_WHOLE_LINE - 1));
  assign v_last = (v_count == v_count_t'(V_WHOLE_FRAME - 1));

  // the position only moves while the display is enabled
  always_ff @(posedge clk) begin
    if (reset) begin
      h_count <= '0;
      v_count <= '0;
    end else if (enable) begin
      if (h_last) begin
        h_count <= '0;
        if (v_last) begin
          v_count <= '0;
        end else begin
          v_count <= v_count + v_count_t'(1);
        end
      end else begin
        h_count <= h_count + h_count_t'(1);
      end
    end
  end

  assign visible = (h_count < h_count_t'(H_VISIBLE)) && (v_count < v_count_t'(V_VISIBLE));

  // syncs are active low
  assign hsync = !((h_count >= h_count_t'(H_SYNC_START)) &&
                   (h_count < h_count_t'(H_SYNC_END)));
  assign vsync = !((v_count >= v_count_t'(V_SYNC_START)) &&
                   (v_count < v_count_t'(V_SYNC_END)));

  // row major, only meaningful inside the visible area
  assign addr = fb_addr_t'(fb_addr_t'(v_count) * fb_addr_t'(H_VISIBLE) + fb_addr_t'(h_count));

endmodule

`default_nettype wire

// File: hw/fade_pkg.sv
`default_nettype none

package fade_pkg;

  // raster timing of the reduced 16x8 screen
  localparam int H_VISIBLE     = 16;
  localparam int H_FRONT_PORCH = 2;
  localparam int H_SYNC_PULSE  = 3;
  localparam int H_BACK_PORCH  = 3;
  localparam int H_WHOLE_LINE  = 24;

  localparam int V_VISIBLE     = 8;
  localparam int V_FRONT_PORCH = 1;
  localparam int V_SYNC_PULSE  = 2;
  localparam int V_BACK_PORCH  = 1;
  localparam int V_WHOLE_FRAME = 12;

  // sync windows, start inclusive and end exclusive
  localparam int H_SYNC_START = H_VISIBLE + H_FRONT_PORCH;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC_PULSE;
  localparam int V_SYNC_START = V_VISIBLE + V_FRONT_PORCH;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC_PULSE;

  localparam int FB_WORDS = H_VISIBLE * V_VISIBLE;

  // fading
  localparam int FADE_START_AGE        = 4;
  localparam int FADE_HALF_AGE         = 2;
  localparam int FADE_FIFO_DEPTH       = 8;
  localparam int FADE_FIFO_ALMOST_FULL = 4;
  localparam int FADE_FIFO_PTR_W       = $clog2(FADE_FIFO_DEPTH);
  localparam int FADE_FIFO_COUNT_W     = $clog2(FADE_FIFO_DEPTH + 1);

  typedef logic [3:0]  color_t;
  typedef logic [11:0] pixel_t;
  typedef logic [3:0]  age_t;
  typedef logic [15:0] fb_word_t;
  typedef logic [3:0]  fb_x_t;
  typedef logic [2:0]  fb_y_t;
  typedef logic [6:0]  fb_addr_t;
  typedef logic [4:0]  h_count_t;
  typedef logic [3:0]  v_count_t;

endpackage

`default_nettype wire
